//--- tb.f
+incdir+logic
logic/wbx_pkg.sv
logic/rr_arbiter.sv
logic/bus_ctrl.sv
logic/master_mux.sv
logic/ram_slave.sv
logic/wb_shared_bus.sv
dv/tb_clkgen.sv
dv/tb_wb_shared_bus.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the shared bus testbench with Verilator and run it.
# Exit status is zero only when the pass message is printed.

cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing -j 0 -f tb.f --top-module tb_wb_shared_bus \
        --Mdir obj_dir -o sim_tb 2>&1 && ./obj_dir/sim_tb 2>&1) \
  || { echo "$out"; echo "Build or simulation run failed"; exit 1; }

echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED" \
  && echo "Simulation result: pass" \
  || { echo "Simulation result: fail"; exit 1; }

//--- dv/tb_wb_shared_bus.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the shared Wishbone bus
// Master tasks drive 1 ns after the rising edge and
// sample ack and read data on the falling edge
// A reference array models the RAM contents
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "wbx_defines.svh"

module tb_wb_shared_bus;

  localparam int N              = `WBX_NUM_MASTERS;
  localparam int AW             = `WBX_ADDR_W;
  localparam int DW             = `WBX_DATA_W;
  localparam int SW             = `WBX_DATA_W / 8;
  localparam int TIMEOUT_CYCLES = 4000;

  logic            clk;
  logic            reset;
  logic [N-1:0]    m_cyc;
  logic [N-1:0]    m_stb;
  logic [N-1:0]    m_we;
  logic [N*AW-1:0] m_adr;
  logic [N*DW-1:0] m_dat;
  logic [N*SW-1:0] m_sel;
  logic [N-1:0]    m_ack;
  logic [DW-1:0]   m_rdat;                            // Shared read data
  logic            grp_release;

  logic [DW-1:0] ref_mem [`WBX_MEM_DEPTH];            // Expected RAM image
  logic [N-1:0]  ack_order [$];                       // One-hot owner per ack
  logic [N-1:0]  ref_mask = '1;                       // Model of the round-robin mask
  integer        seed = 32'h6f14_015d;
  int            err_count = 0;
  int            checks = 0;
  int            rel_pulses = 0;                      // grp_release_o highs seen
  int            ack_pulses = 0;                      // Ack bits seen high, all masters
  int            cycles = 0;

  tb_clkgen u_clkgen (.clk_o(clk), .reset_o(reset));

  wb_shared_bus uut (
    .clk(clk), .reset(reset),
    .m_cyc_i(m_cyc), .m_stb_i(m_stb), .m_we_i(m_we),
    .m_adr_i(m_adr), .m_dat_i(m_dat), .m_sel_i(m_sel),
    .m_ack_o(m_ack), .m_dat_o(m_rdat), .grp_release_o(grp_release)
  );

  task automatic check_data(input string sig, input logic [DW-1:0] exp, input logic [DW-1:0] act);
    checks++;
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] t=%0t %s expected %h got %h", $time, sig, exp, act);
    end
  endtask

  task automatic check_order(input string sig, input logic [N-1:0] exp, input logic [N-1:0] act);
    checks++;
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] t=%0t %s expected %b got %b", $time, sig, exp, act);
    end
  endtask

  task automatic check_state(input string sig, input wbx_pkg::bus_state_e exp,
                             input wbx_pkg::bus_state_e act);
    checks++;
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] t=%0t %s expected %s got %s", $time, sig, exp.name(), act.name());
    end
  endtask

  task automatic check_count(input string sig, input int exp, input int act);
    checks++;
    if (act != exp) begin
      err_count++;
      $display("[ERROR] t=%0t %s expected %0d got %0d", $time, sig, exp, act);
    end
  endtask

  task automatic check_bit(input string sig, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] t=%0t %s expected %b got %b", $time, sig, exp, act);
    end
  endtask

  function automatic logic [N-1:0] onehot(input int idx);
    logic [N-1:0] r;
    r      = '0;
    r[idx] = 1'b1;
    return r;
  endfunction

  // Selected lanes take the new byte
  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_w,
                                                input logic [DW-1:0] new_w,
                                                input logic [SW-1:0] sel);
    logic [DW-1:0] r;
    r = old_w;
    for (int b = 0; b < SW; b++) begin
      if (sel[b]) r[8*b +: 8] = new_w[8*b +: 8];
    end
    return r;
  endfunction

  task automatic start_xfer(input int n, input wbx_pkg::bus_op_e op, input logic [AW-1:0] adr,
                            input logic [DW-1:0] dat, input logic [SW-1:0] sel);
    m_cyc[n]            = 1'b1;
    m_stb[n]            = 1'b1;
    m_we[n]             = (op == wbx_pkg::OP_WRITE);
    m_adr[n*AW +: AW]   = adr;
    m_dat[n*DW +: DW]   = dat;
    m_sel[n*SW +: SW]   = sel;
  endtask

  // Edges from request to ack, read word captured with it
  task automatic wait_ack(input int n, input logic hold_chk, output int lat,
                          output logic [DW-1:0] rd);
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      @(negedge clk);
      if (hold_chk) check_state("state_w", wbx_pkg::ST_OWNED, uut.state_w);
    end while (!m_ack[n]);
    rd = m_rdat;
    ack_order.push_back(onehot(n));
  endtask

  task automatic end_xfer(input int n);
    @(posedge clk);
    #1;
    m_cyc[n] = 1'b0;                                  // Drop cyc so the bus is released
    m_stb[n] = 1'b0;
    m_we[n]  = 1'b0;
  endtask

  task automatic wb_write(input int n, input logic [AW-1:0] adr, input logic [DW-1:0] dat,
                          input logic [SW-1:0] sel, output int lat);
    logic [DW-1:0] rd;
    @(posedge clk);
    #1;
    start_xfer(n, wbx_pkg::OP_WRITE, adr, dat, sel);
    wait_ack(n, 1'b0, lat, rd);
    ref_mem[adr] = merge_bytes(ref_mem[adr], dat, sel);
    end_xfer(n);
  endtask

  task automatic wb_read(input int n, input logic [AW-1:0] adr, output logic [DW-1:0] rd,
                         output int lat);
    @(posedge clk);
    #1;
    start_xfer(n, wbx_pkg::OP_READ, adr, '0, '0);
    wait_ack(n, 1'b0, lat, rd);
    end_xfer(n);
  endtask

  // Block write with cyc held, stb kept high between beats
  task automatic wb_block(input int n, input logic [AW-1:0] base, input int count);
    logic [DW-1:0] dat;
    logic [DW-1:0] rd;
    logic [AW-1:0] adr;
    int            lat;
    @(posedge clk);
    #1;
    for (int k = 0; k < count; k++) begin
      dat = $random(seed);
      adr = base + AW'(k);
      if (k == 0) begin
        start_xfer(n, wbx_pkg::OP_WRITE, adr, dat, '1);
      end else begin
        @(posedge clk);
        #1;
        m_adr[n*AW +: AW] = adr;                      // Next beat, same cycle
        m_dat[n*DW +: DW] = dat;
      end
      wait_ack(n, (k > 0), lat, rd);
      ref_mem[adr] = dat;
    end
    end_xfer(n);
  endtask

  // Checks grp_release_o in every adv cycle against the mask rule
  task automatic watch_release();
    logic [N-1:0] cand;
    logic [N-1:0] nxt;
    logic [N-1:0] ones;
    int           gi;
    ones = '1;
    forever begin
      @(negedge clk);
      if (grp_release) rel_pulses++;
      if (uut.adv_w) begin
        cand = m_cyc & ref_mask;
        if (cand == '0) cand = m_cyc;                 // Round spent, raw requests
        gi = 0;
        for (int i = N - 1; i >= 0; i--) begin
          if (cand[i]) gi = i;
        end
        nxt = ones << (gi + 1);
        check_bit("grp_release_o", (nxt > ref_mask), grp_release);
        ref_mask = nxt;
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %s finished with %0d errors", name, err_count - errs_before);
  endtask

  task automatic test_contention();
    int            e0;
    int            a0;
    int            lat [N];
    logic [DW-1:0] d [N];
    e0 = err_count;
    a0 = ack_pulses;
    check_state("state_w", wbx_pkg::ST_IDLE, uut.state_w);
    check_order("m_ack_o", '0, m_ack);
    for (int i = 0; i < N; i++) d[i] = $random(seed);
    ack_order.delete();
    fork
      wb_write(0, 8'h10, d[0], '1, lat[0]);
      wb_write(1, 8'h11, d[1], '1, lat[1]);
      wb_write(2, 8'h12, d[2], '1, lat[2]);
      wb_write(3, 8'h13, d[3], '1, lat[3]);
    join
    check_count("m_ack_o pulses", N, ack_pulses - a0);
    for (int i = 0; i < N; i++) check_order("ack order", onehot(i), ack_order[i]);
    report_test("contention", e0);
  endtask

  task automatic test_rotation();
    int e0;
    int a0;
    int la;
    int lb;
    int lc;
    e0 = err_count;
    a0 = ack_pulses;
    ack_order.delete();
    wb_write(2, 8'h20, $random(seed), '1, la);
    fork
      wb_write(1, 8'h21, 32'h1111_0001, '1, lb);
      wb_write(3, 8'h23, 32'h3333_0003, '1, lc);
    join
    check_count("m_ack_o pulses", 3, ack_pulses - a0);
    check_order("ack order", onehot(3), ack_order[1]); // Mask keeps only index 3
    check_order("ack order", onehot(1), ack_order[2]);
    report_test("rotation", e0);
  endtask

  task automatic test_hold();
    int e0;
    int a0;
    int lat;
    e0 = err_count;
    a0 = ack_pulses;
    ack_order.delete();
    fork
      wb_block(1, 8'h40, 4);
      begin
        repeat (3) @(posedge clk);                    // Request once master 1 owns
        wb_write(0, 8'h50, $random(seed), '1, lat);
      end
    join
    check_count("m_ack_o pulses", 5, ack_pulses - a0);
    for (int i = 0; i < 4; i++) check_order("ack order", onehot(1), ack_order[i]);
    check_order("ack order", onehot(0), ack_order[4]);
    report_test("bus hold", e0);
  endtask

  task automatic test_solo();
    int            e0;
    int            lat;
    logic [AW-1:0] adr;
    logic [DW-1:0] rd;
    e0 = err_count;
    for (int n = 0; n < N; n++) begin
      for (int k = 0; k < 2; k++) begin
        adr = 8'h80 + AW'(n * 8 + k);
        wb_write(n, adr, $random(seed), '1, lat);
        check_count("write ack latency", 2, lat);
        wb_read(n, adr, rd, lat);
        check_count("read ack latency", 2, lat);
        check_data("m_dat_o", ref_mem[adr], rd);
      end
    end
    report_test("single master", e0);
  endtask

  task automatic test_byte_sel();
    int            e0;
    int            lat;
    logic [DW-1:0] rd;
    logic [SW-1:0] sels [3];
    e0   = err_count;
    sels = '{4'b0001, 4'b0110, 4'b1010};
    for (int k = 0; k < 4; k++) begin                 // Block words from the hold test
      wb_read(2, 8'h40 + AW'(k), rd, lat);
      check_data("m_dat_o", ref_mem[8'h40 + AW'(k)], rd);
    end
    wb_write(2, 8'hE0, $random(seed), '1, lat);
    for (int i = 0; i < 3; i++) begin
      wb_write(2, 8'hE0, $random(seed), sels[i], lat);
      wb_read(2, 8'hE0, rd, lat);
      check_data("m_dat_o", ref_mem[8'hE0], rd);
    end
    report_test("byte select", e0);
  endtask

  // Refills: grants to 2 and 1 in rotation, 0 after the hold, 2 in byte select
  task automatic test_grp_release();
    int e0;
    e0 = err_count;
    check_count("grp_release_o pulses", 4, rel_pulses);
    report_test("group release", e0);
  endtask

  // One count per master bit per cycle with ack high
  always @(negedge clk) begin
    ack_pulses <= ack_pulses + $countones(m_ack);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a master never got its ack", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    m_cyc = '0;
    m_stb = '0;
    m_we  = '0;
    m_adr = '0;
    m_dat = '0;
    m_sel = '0;
    fork
      watch_release();
    join_none
    wait (reset === 1'b0);
    test_contention();                                // Needs the mask fresh from reset
    test_rotation();
    test_hold();
    test_solo();
    test_byte_sel();
    test_grp_release();
    $display("Summary: %0d checks, %0d errors", checks, err_count);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/tb_clkgen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock and reset source for the shared bus testbench
// 8 ns clock; reset high for the first two edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
  parameter int HALF_NS      = 4,                     // Half of the 8 ns period
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #HALF_NS clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 reset_o = 1'b0;                                // Release off the edge
  end

endmodule

`default_nettype wire

//--- logic/wb_shared_bus.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the shared Wishbone bus
// Four masters, one RAM slave. Master n uses slice n
// of every flattened port; read data is shared
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "wbx_defines.svh"

module wb_shared_bus (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic [`WBX_NUM_MASTERS-1:0]                 m_cyc_i,
  input  logic [`WBX_NUM_MASTERS-1:0]                 m_stb_i,
  input  logic [`WBX_NUM_MASTERS-1:0]                 m_we_i,
  input  logic [`WBX_NUM_MASTERS*`WBX_ADDR_W-1:0]     m_adr_i,
  input  logic [`WBX_NUM_MASTERS*`WBX_DATA_W-1:0]     m_dat_i,
  input  logic [`WBX_NUM_MASTERS*(`WBX_DATA_W/8)-1:0] m_sel_i,
  output logic [`WBX_NUM_MASTERS-1:0]                 m_ack_o,
  output logic [`WBX_DATA_W-1:0]                      m_dat_o,
  output logic                                        grp_release_o
);

  logic [`WBX_NUM_MASTERS-1:0] gnt_w;                 // Arbiter pick
  logic                        adv_w;                 // Grant consumed
  logic [`WBX_NUM_MASTERS-1:0] owner_oh_w;            // Latched owner
  wbx_pkg::bus_state_e         state_w;               // Read by the testbench
  logic                        s_cyc_w;
  logic                        s_stb_w;
  logic                        s_we_w;
  logic [`WBX_ADDR_W-1:0]      s_adr_w;
  logic [`WBX_DATA_W-1:0]      s_dat_w_w;
  logic [`WBX_DATA_W/8-1:0]    s_sel_w;
  logic                        s_ack_w;
  logic [`WBX_DATA_W-1:0]      s_dat_r_w;

  rr_arbiter u_arb (
    .clk(clk), .reset(reset), .adv_i(adv_w),
    .req_i(m_cyc_i), .gnt_o(gnt_w), .grp_release_o(grp_release_o)
  );

  bus_ctrl u_ctrl (
    .clk(clk), .reset(reset), .m_cyc_i(m_cyc_i), .gnt_i(gnt_w),
    .adv_o(adv_w), .owner_oh_o(owner_oh_w), .state_o(state_w)
  );

  master_mux u_mux (
    .owner_oh_i(owner_oh_w),
    .m_cyc_i(m_cyc_i), .m_stb_i(m_stb_i), .m_we_i(m_we_i),
    .m_adr_i(m_adr_i), .m_dat_i(m_dat_i), .m_sel_i(m_sel_i),
    .s_ack_i(s_ack_w), .s_dat_r_i(s_dat_r_w),
    .s_cyc_o(s_cyc_w), .s_stb_o(s_stb_w), .s_we_o(s_we_w),
    .s_adr_o(s_adr_w), .s_dat_w_o(s_dat_w_w), .s_sel_o(s_sel_w),
    .m_ack_o(m_ack_o), .m_dat_o(m_dat_o)
  );

  ram_slave u_ram (
    .clk(clk), .reset(reset),
    .cyc_i(s_cyc_w), .stb_i(s_stb_w), .we_i(s_we_w),
    .adr_i(s_adr_w), .dat_i(s_dat_w_w), .sel_i(s_sel_w),
    .ack_o(s_ack_w), .dat_o(s_dat_r_w)
  );

endmodule

`default_nettype wire

//--- logic/ram_slave.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic RAM slave
// One registered ack per transfer, low for a cycle
// between back-to-back strobes. Writes honour sel_i
// per byte; reads return the whole word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "wbx_defines.svh"

module ram_slave (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cyc_i,
  input  logic                     stb_i,
  input  logic                     we_i,
  input  logic [`WBX_ADDR_W-1:0]   adr_i,             // Word address
  input  logic [`WBX_DATA_W-1:0]   dat_i,             // Write data
  input  logic [`WBX_DATA_W/8-1:0] sel_i,             // Byte lanes to write
  output logic                     ack_o,
  output logic [`WBX_DATA_W-1:0]   dat_o              // Registered read word
);

  localparam int DW    = `WBX_DATA_W;
  localparam int SW    = `WBX_DATA_W / 8;
  localparam int DEPTH = `WBX_MEM_DEPTH;

  logic [DW-1:0]    mem [DEPTH];
  wbx_pkg::bus_op_e op;
  logic             access;                           // New transfer this cycle

  assign op     = wbx_pkg::bus_op_e'(we_i);
  assign access = cyc_i & stb_i & ~ack_o;             // Skip the cycle ack is up

  always_ff @(posedge clk) begin
    if (access) begin
      if (op == wbx_pkg::OP_WRITE) begin
        for (int b = 0; b < SW; b++) begin
          if (sel_i[b]) mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8];
        end
      end else begin
        dat_o <= mem[adr_i];
      end
    end
  end

  // Ack lasts exactly one cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
    end
  end

endmodule

`default_nettype wire

//--- logic/master_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Master multiplexer, purely combinational
// AND-OR selects the owner's request toward the RAM;
// ack goes back to the owner only, read data to all
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "wbx_defines.svh"

module master_mux (
  input  logic [`WBX_NUM_MASTERS-1:0]                  owner_oh_i,
  input  logic [`WBX_NUM_MASTERS-1:0]                  m_cyc_i,
  input  logic [`WBX_NUM_MASTERS-1:0]                  m_stb_i,
  input  logic [`WBX_NUM_MASTERS-1:0]                  m_we_i,
  input  logic [`WBX_NUM_MASTERS*`WBX_ADDR_W-1:0]      m_adr_i,
  input  logic [`WBX_NUM_MASTERS*`WBX_DATA_W-1:0]      m_dat_i,
  input  logic [`WBX_NUM_MASTERS*(`WBX_DATA_W/8)-1:0]  m_sel_i,
  input  logic                                         s_ack_i,
  input  logic [`WBX_DATA_W-1:0]                       s_dat_r_i,
  output logic                                         s_cyc_o,
  output logic                                         s_stb_o,
  output logic                                         s_we_o,
  output logic [`WBX_ADDR_W-1:0]                       s_adr_o,
  output logic [`WBX_DATA_W-1:0]                       s_dat_w_o,
  output logic [`WBX_DATA_W/8-1:0]                     s_sel_o,
  output logic [`WBX_NUM_MASTERS-1:0]                  m_ack_o,
  output logic [`WBX_DATA_W-1:0]                       m_dat_o
);

  localparam int N  = `WBX_NUM_MASTERS;
  localparam int AW = `WBX_ADDR_W;
  localparam int DW = `WBX_DATA_W;
  localparam int SW = `WBX_DATA_W / 8;

  // No owner means every slave signal is zero
  always_comb begin
    s_cyc_o   = 1'b0;
    s_stb_o   = 1'b0;
    s_we_o    = 1'b0;
    s_adr_o   = '0;
    s_dat_w_o = '0;
    s_sel_o   = '0;
    for (int i = 0; i < N; i++) begin
      s_cyc_o   = s_cyc_o | (owner_oh_i[i] & m_cyc_i[i]);
      s_stb_o   = s_stb_o | (owner_oh_i[i] & m_stb_i[i]);
      s_we_o    = s_we_o | (owner_oh_i[i] & m_we_i[i]);
      s_adr_o   = s_adr_o | ({AW{owner_oh_i[i]}} & m_adr_i[i*AW +: AW]);
      s_dat_w_o = s_dat_w_o | ({DW{owner_oh_i[i]}} & m_dat_i[i*DW +: DW]);
      s_sel_o   = s_sel_o | ({SW{owner_oh_i[i]}} & m_sel_i[i*SW +: SW]);
    end
  end

  assign m_ack_o = owner_oh_i & {N{s_ack_i}};          // Waiting masters never see ack
  assign m_dat_o = s_dat_r_i;                          // Shared read bus

endmodule

`default_nettype wire

//--- logic/bus_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus ownership controller
// Latches the arbiter grant when idle and keeps it
// while the owner holds cyc, so block transfers stay
// together. adv_o tells the arbiter a grant was used
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "wbx_defines.svh"

module bus_ctrl (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`WBX_NUM_MASTERS-1:0] m_cyc_i,        // cyc from every master
  input  logic [`WBX_NUM_MASTERS-1:0] gnt_i,          // One-hot grant from arbiter
  output logic                        adv_o,          // Ownership taken this cycle
  output logic [`WBX_NUM_MASTERS-1:0] owner_oh_o,     // Current owner, zero when idle
  output wbx_pkg::bus_state_e         state_o
);

  wbx_pkg::bus_state_e                state_q;
  logic [`WBX_NUM_MASTERS-1:0]        owner_oh_q;
  logic                               owner_cyc;      // Owner still in a cycle

  assign owner_cyc = |(m_cyc_i & owner_oh_q);

  // Take the bus only from idle
  assign adv_o = (state_q == wbx_pkg::ST_IDLE) && (|gnt_i);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q    <= wbx_pkg::ST_IDLE;
      owner_oh_q <= '0;
    end else begin
      case (state_q)
        wbx_pkg::ST_IDLE: begin
          if (|gnt_i) begin
            owner_oh_q <= gnt_i;                      // Freeze the winner
            state_q    <= wbx_pkg::ST_OWNED;
          end
        end
        wbx_pkg::ST_OWNED: begin
          // Hold across stb gaps, release on cyc drop
          if (!owner_cyc) begin
            owner_oh_q <= '0;
            state_q    <= wbx_pkg::ST_IDLE;
          end
        end
        default: begin
          owner_oh_q <= '0;                           // Recover to idle
          state_q    <= wbx_pkg::ST_IDLE;
        end
      endcase
    end
  end

  assign owner_oh_o = owner_oh_q;
  assign state_o    = state_q;

endmodule

`default_nettype wire

//--- logic/rr_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter for the shared bus masters
// Grant is combinational from req_i; the mask moves
// past the winner on adv_i and refills when empty
// grp_release_o flags each refill in the adv cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "wbx_defines.svh"

module rr_arbiter (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        adv_i,          // Grant taken, advance mask
  input  logic [`WBX_NUM_MASTERS-1:0] req_i,          // One request per master
  output logic [`WBX_NUM_MASTERS-1:0] gnt_o,          // One-hot grant
  output logic                        grp_release_o   // Mask refilled
);

  localparam int N = `WBX_NUM_MASTERS;

  logic [N-1:0] mask_q;                               // Masters still eligible this round
  logic [N-1:0] nxt_mask;                             // Mask after current grant
  logic [N-1:0] mask_req;                             // Requests inside the mask
  logic [N-1:0] mask_gnt;                             // Pick from masked set
  logic [N-1:0] raw_gnt;                              // Pick from all requests

  // Lowest index wins
  function automatic logic [N-1:0] pick_lowest(input logic [N-1:0] req);
    logic [N-1:0] gnt;
    logic         found;
    gnt   = '0;
    found = 1'b0;
    for (int i = 0; i < N; i++) begin
      if (req[i] && !found) begin
        gnt[i] = 1'b1;
        found  = 1'b1;
      end
    end
    return gnt;
  endfunction

  assign mask_req = req_i & mask_q;
  assign mask_gnt = pick_lowest(mask_req);
  assign raw_gnt  = pick_lowest(req_i);
  assign gnt_o    = (|mask_req) ? mask_gnt : raw_gnt; // Fall back once round is spent

  // Keep only the indices above the winner
  always_comb begin
    nxt_mask = mask_q;
    for (int i = 0; i < N; i++) begin
      if (gnt_o[i]) nxt_mask = {N{1'b1}} << (i + 1);
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mask_q <= '1;                                   // Everyone eligible
    end else if (adv_i) begin
      mask_q <= nxt_mask;
    end
  end

  // Wider mask next means a new round started
  assign grp_release_o = adv_i && (nxt_mask > mask_q);

endmodule

`default_nettype wire

//--- logic/wbx_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the Wishbone shared bus
// Referenced by scoped name, wbx_pkg::name
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package wbx_pkg;

  // Bus controller ownership state
  typedef enum logic {
    ST_IDLE  = 1'b0,                          // Nobody owns the bus
    ST_OWNED = 1'b1                           // One master holds the bus
  } bus_state_e;

  // Transfer kind, taken straight from we
  typedef enum logic {
    OP_READ  = 1'b0,                          // we low
    OP_WRITE = 1'b1                           // we high
  } bus_op_e;

endpackage

`default_nettype wire

//--- logic/wbx_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizing macros for the shared Wishbone bus project
// Include in any file that needs master count,
// bus widths or RAM depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef WBX_DEFINES_SVH
`define WBX_DEFINES_SVH

// Number of bus masters sharing the slave
`define WBX_NUM_MASTERS 4

// Word address width on the bus
`define WBX_ADDR_W 8

// Data width, byte selects are this over 8
`define WBX_DATA_W 32

// On-chip RAM size in words
`define WBX_MEM_DEPTH 256

`endif
